/* Makefile */
# Verilator build and run of the PDP-8 core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f list.f --top-module tbPdp8 -Mdir obj_dir -o VtbPdp8

run: compile
	./obj_dir/VtbPdp8

clean:
	rm -rf obj_dir

/* common/pdp8Pkg.sv */
// PDP-8 shared types
// Panel port structs, opcode and state enums, and the control word
// that the sequencer hands to the datapath blocks each cycle

`default_nettype none

`include "pdp8_cfg.svh"

package pdp8Pkg;

  typedef logic [`PDP8_WORD_BITS-1:0] word;

  typedef enum logic [1:0] {opDeposit, opExamine, opRun} panelOp;

  typedef struct packed {
    panelOp op;
    word addr;
    word data;
  } panelCmd;

  // Valid while ack is high
  typedef struct packed {
    word data;
    word ac;
    word pc;
    logic link;
  } panelResp;

  // Top three bits of the instruction
  typedef enum logic [2:0] {
    opAnd, opTad, opIsz, opDca, opJms, opJmp, opIot, opOpr
  } memOp;

  typedef enum logic [2:0] {
    stIdle, stFetch, stDefer, stAutoWrite, stExec, stExecWrite, stHalt
  } seqState;

  typedef enum logic [2:0] {accHold, accAnd, accTad, accClear, accOpr} accOp;

  typedef enum logic [2:0] {pcHold, pcInc, pcLoadMa, pcLoadMaInc, pcLoadPanel} pcOp;

  typedef enum logic [1:0] {maFromPc, maFromIr, maFromData, maHold} maSel;

  // Source of the memory write data
  typedef enum logic [1:0] {wrAcc, wrInc, wrPc} wrSel;

  typedef struct packed {
    accOp accOp;
    pcOp pcOp;
    maSel maSel;
    wrSel wrSel;
    logic irLoad;
    logic memWrite;
    logic oprSkipEnable;
  } cpuCtl;

endpackage

`default_nettype wire

/* common/pdp8_cfg.svh */
// PDP-8 core configuration
// Word and address widths, and the auto-index window in page zero

`ifndef PDP8_CFG_SVH
`define PDP8_CFG_SVH

// Data word width
`define PDP8_WORD_BITS 12

// Memory address width, 4096 words
`define PDP8_ADDR_BITS 12

// Auto-index locations 0010..0017 octal
`define PDP8_AUTOINDEX_FIRST 12'o0010
`define PDP8_AUTOINDEX_LAST 12'o0017

`endif

/* cpu/pdp8AccUnit.sv */
// PDP-8 accumulator unit
// AC and link with the AND/TAD path, the group 1 operate chain
// and the group 2 skip condition

`timescale 1ns/1ps
`default_nettype none

module pdp8AccUnit (
  input  logic clk,
  input  logic reset,
  input  pdp8Pkg::cpuCtl ctl,
  input  pdp8Pkg::word ir,
  input  pdp8Pkg::word memData,
  output pdp8Pkg::word ac,
  output logic link,
  output logic skip
);

  logic [12:0] sum;
  logic [12:0] g1;
  logic [12:0] g1Rot;
  logic skipCond;

  assign sum = {1'b0, ac} + {1'b0, memData};

  // Group 1 in order: clear, complement, increment
  always_comb begin
    g1 = {link, ac};
    if (ir[7]) g1[11:0] = '0;
    if (ir[6]) g1[12] = 1'b0;
    if (ir[5]) g1[11:0] = ~g1[11:0];
    if (ir[4]) g1[12] = ~g1[12];
    if (ir[0]) g1 = g1 + 13'd1;
  end

  // Then rotate through the link, or byte swap
  always_comb begin
    case (ir[3:1])
      3'b100: g1Rot = {g1[0], g1[12:1]};
      3'b101: g1Rot = {g1[1:0], g1[12:2]};
      3'b010: g1Rot = {g1[11:0], g1[12]};
      3'b011: g1Rot = {g1[10:0], g1[12:11]};
      3'b001: g1Rot = {g1[12], g1[5:0], g1[11:6]};
      default: g1Rot = g1;
    endcase
  end

  // SMA, SZA, SNL; bit 3 turns them into SPA, SNA, SZL
  assign skipCond = (ir[6] && ac[11]) || (ir[5] && (ac == '0)) || (ir[4] && link);
  assign skip = ir[3] ? !skipCond : skipCond;

  always_ff @(posedge clk) begin
    if (reset) begin
      ac <= '0;
      link <= 1'b0;
    end else begin
      case (ctl.accOp)
        pdp8Pkg::accAnd: ac <= ac & memData;
        pdp8Pkg::accTad: begin
          ac <= sum[11:0];
          link <= link ^ sum[12];
        end
        pdp8Pkg::accClear: ac <= '0;
        pdp8Pkg::accOpr: begin
          if (ctl.oprSkipEnable) begin
            // Group 2 only clears AC
            if (ir[7]) ac <= '0;
          end else if (!ir[8]) begin
            {link, ac} <= g1Rot;
          end
        end
        default: begin
          ac <= ac;
          link <= link;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* cpu/pdp8Sequencer.sv */
// PDP-8 sequencer
// Holds the instruction register, decodes it and walks the major
// states, issuing one control word per cycle. Also runs the
// front-panel req/ack handshake and stops a run at HLT

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module pdp8Sequencer (
  input  logic clk,
  input  logic reset,
  input  pdp8Pkg::panelCmd cmd,
  input  logic req,
  input  pdp8Pkg::word memData,
  input  logic skip,
  output pdp8Pkg::cpuCtl ctl,
  output pdp8Pkg::word ir,
  output logic panelBusy,
  output logic ack
);

  pdp8Pkg::seqState state;
  pdp8Pkg::seqState stateNext;
  logic phase;
  logic phaseNext;
  pdp8Pkg::word irReg;
  logic loadIr;
  logic panelFirst;
  pdp8Pkg::memOp opc;
  logic isMemRef;
  logic autoIdx;
  logic grp2;

  // Instruction word is visible in the same cycle it is loaded
  assign loadIr = (state == pdp8Pkg::stFetch) && phase;
  assign ir = loadIr ? memData : irReg;

  assign opc = pdp8Pkg::memOp'(ir[11:9]);
  assign isMemRef = (opc != pdp8Pkg::opIot) && (opc != pdp8Pkg::opOpr);
  assign autoIdx = ir[8] && !ir[7] &&
                   ({5'b0, ir[6:0]} >= `PDP8_AUTOINDEX_FIRST) &&
                   ({5'b0, ir[6:0]} <= `PDP8_AUTOINDEX_LAST);
  assign grp2 = ir[8] && !ir[0];

  always_comb begin
    ctl = '{accOp: pdp8Pkg::accHold, pcOp: pdp8Pkg::pcHold, maSel: pdp8Pkg::maHold,
            wrSel: pdp8Pkg::wrAcc, irLoad: loadIr, memWrite: 1'b0, oprSkipEnable: 1'b0};
    stateNext = state;
    phaseNext = 1'b0;
    case (state)
      pdp8Pkg::stIdle: begin
        if (panelBusy) begin
          // Single write strobe per deposit
          ctl.memWrite = panelFirst && (cmd.op == pdp8Pkg::opDeposit);
        end else if (req && !ack && (cmd.op == pdp8Pkg::opRun)) begin
          ctl.pcOp = pdp8Pkg::pcLoadPanel;
          ctl.maSel = pdp8Pkg::maFromPc;
          stateNext = pdp8Pkg::stFetch;
        end
      end
      pdp8Pkg::stFetch: begin
        if (!phase) begin
          phaseNext = 1'b1;
        end else begin
          ctl.pcOp = pdp8Pkg::pcInc;
          ctl.maSel = pdp8Pkg::maFromIr;
          stateNext = (isMemRef && ir[8]) ? pdp8Pkg::stDefer : pdp8Pkg::stExec;
        end
      end
      pdp8Pkg::stDefer: begin
        if (!phase) begin
          phaseNext = 1'b1;
        end else if (autoIdx) begin
          stateNext = pdp8Pkg::stAutoWrite;
        end else begin
          ctl.maSel = pdp8Pkg::maFromData;
          stateNext = pdp8Pkg::stExec;
        end
      end
      pdp8Pkg::stAutoWrite: begin
        // Pointer+1 goes back to memory and into MA
        ctl.memWrite = 1'b1;
        ctl.wrSel = pdp8Pkg::wrInc;
        ctl.maSel = pdp8Pkg::maFromData;
        stateNext = pdp8Pkg::stExec;
      end
      pdp8Pkg::stExec: begin
        case (opc)
          pdp8Pkg::opJmp: begin
            ctl.pcOp = pdp8Pkg::pcLoadMa;
            ctl.maSel = pdp8Pkg::maFromPc;
            stateNext = pdp8Pkg::stFetch;
          end
          pdp8Pkg::opOpr: begin
            ctl.accOp = pdp8Pkg::accOpr;
            ctl.oprSkipEnable = grp2;
            ctl.pcOp = (grp2 && skip) ? pdp8Pkg::pcInc : pdp8Pkg::pcHold;
            ctl.maSel = pdp8Pkg::maFromPc;
            stateNext = (grp2 && ir[1]) ? pdp8Pkg::stHalt : pdp8Pkg::stFetch;
          end
          pdp8Pkg::opIot: begin
            // No devices, acts as a NOP
            ctl.maSel = pdp8Pkg::maFromPc;
            stateNext = pdp8Pkg::stFetch;
          end
          default: begin
            if (!phase) begin
              phaseNext = 1'b1;
            end else if (opc == pdp8Pkg::opAnd || opc == pdp8Pkg::opTad) begin
              ctl.accOp = (opc == pdp8Pkg::opAnd) ? pdp8Pkg::accAnd : pdp8Pkg::accTad;
              ctl.maSel = pdp8Pkg::maFromPc;
              stateNext = pdp8Pkg::stFetch;
            end else begin
              stateNext = pdp8Pkg::stExecWrite;
            end
          end
        endcase
      end
      pdp8Pkg::stExecWrite: begin
        ctl.memWrite = 1'b1;
        ctl.maSel = pdp8Pkg::maFromPc;
        stateNext = pdp8Pkg::stFetch;
        case (opc)
          pdp8Pkg::opIsz: begin
            ctl.wrSel = pdp8Pkg::wrInc;
            ctl.pcOp = pdp8Pkg::pcInc;
          end
          pdp8Pkg::opJms: begin
            ctl.wrSel = pdp8Pkg::wrPc;
            ctl.pcOp = pdp8Pkg::pcLoadMaInc;
          end
          default: begin
            ctl.wrSel = pdp8Pkg::wrAcc;
            ctl.accOp = pdp8Pkg::accClear;
          end
        endcase
      end
      pdp8Pkg::stHalt: begin
        if (ack && !req) stateNext = pdp8Pkg::stIdle;
      end
      default: stateNext = pdp8Pkg::stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pdp8Pkg::stIdle;
      phase <= 1'b0;
      ack <= 1'b0;
      panelBusy <= 1'b0;
      panelFirst <= 1'b0;
    end else begin
      state <= stateNext;
      phase <= phaseNext;
      panelFirst <= 1'b0;
      if (state == pdp8Pkg::stIdle) begin
        if (!panelBusy && req && !ack && (cmd.op != pdp8Pkg::opRun)) begin
          panelBusy <= 1'b1;
          panelFirst <= 1'b1;
        end else if (panelBusy && !panelFirst && !ack) begin
          ack <= 1'b1;
        end else if (ack && !req) begin
          ack <= 1'b0;
          panelBusy <= 1'b0;
        end
      end
      // Run ends here, ack until the master lets go of req
      if (state == pdp8Pkg::stHalt) begin
        if (!ack) ack <= 1'b1;
        else if (!req) ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loadIr) irReg <= memData;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/pdp8Pkg.sv
src/pdp8Memory.sv
src/pdp8AddrUnit.sv
cpu/pdp8AccUnit.sv
cpu/pdp8Sequencer.sv
src/pdp8Core.sv
tests/tbPdp8.sv

/* src/pdp8AddrUnit.sv */
// PDP-8 address unit
// Program counter and memory address register. Forms page-zero and
// current-page addresses, follows indirect pointers and handles the
// ISZ skip by testing the incremented word itself

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module pdp8AddrUnit (
  input  logic clk,
  input  logic reset,
  input  pdp8Pkg::cpuCtl ctl,
  input  pdp8Pkg::word ir,
  input  pdp8Pkg::word memData,
  input  pdp8Pkg::word panelAddr,
  output pdp8Pkg::word pc,
  output pdp8Pkg::word ma,
  output pdp8Pkg::word incWord
);

  pdp8Pkg::word pcNext;
  pdp8Pkg::word effAddr;
  logic [4:0] pageBits;
  logic autoIdx;
  logic iszWrite;

  // MA is loaded from IR while the PC still points at the instruction
  assign pageBits = pc[11:7];
  assign effAddr = {ir[7] ? pageBits : 5'b0, ir[6:0]};
  assign autoIdx = ir[8] && !ir[7] &&
                   (effAddr >= `PDP8_AUTOINDEX_FIRST) && (effAddr <= `PDP8_AUTOINDEX_LAST);

  assign incWord = memData + 1'b1;
  assign iszWrite = ctl.memWrite && (ctl.wrSel == pdp8Pkg::wrInc);

  always_comb begin
    case (ctl.pcOp)
      // ISZ skips only when the stored word wraps to zero
      pdp8Pkg::pcInc: pcNext = (iszWrite && (incWord != '0)) ? pc : pc + 1'b1;
      pdp8Pkg::pcLoadMa: pcNext = ma;
      pdp8Pkg::pcLoadMaInc: pcNext = ma + 1'b1;
      pdp8Pkg::pcLoadPanel: pcNext = panelAddr;
      default: pcNext = pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      ma <= '0;
    end else begin
      pc <= pcNext;
      case (ctl.maSel)
        pdp8Pkg::maFromPc: ma <= pcNext;
        pdp8Pkg::maFromIr: ma <= effAddr;
        pdp8Pkg::maFromData: ma <= autoIdx ? incWord : memData;
        default: ma <= ma;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/pdp8Core.sv */
// PDP-8 processor top level
// Sequencer, address unit, accumulator unit and memory, with the
// front-panel port sharing the single memory port

`timescale 1ns/1ps
`default_nettype none

module pdp8Core (
  input  logic clk,
  input  logic reset,
  input  pdp8Pkg::panelCmd cmd,
  input  logic req,
  output logic ack,
  output pdp8Pkg::panelResp resp
);

  pdp8Pkg::cpuCtl ctl;
  pdp8Pkg::word ir;
  pdp8Pkg::word memData;
  pdp8Pkg::word memAddr;
  pdp8Pkg::word wrData;
  pdp8Pkg::word pc;
  pdp8Pkg::word ma;
  pdp8Pkg::word incWord;
  pdp8Pkg::word ac;
  logic link;
  logic skip;
  logic panelBusy;

  // Panel owns the memory port during deposit and examine
  assign memAddr = panelBusy ? cmd.addr : ma;

  always_comb begin
    if (panelBusy) wrData = cmd.data;
    else begin
      case (ctl.wrSel)
        pdp8Pkg::wrInc: wrData = incWord;
        pdp8Pkg::wrPc: wrData = pc;
        default: wrData = ac;
      endcase
    end
  end

  assign resp = '{data: memData, ac: ac, pc: pc, link: link};

  pdp8Sequencer sequencer_i (
    .clk(clk), .reset(reset), .cmd(cmd), .req(req),
    .memData(memData), .skip(skip),
    .ctl(ctl), .ir(ir), .panelBusy(panelBusy), .ack(ack)
  );

  pdp8AddrUnit addrUnit_i (
    .clk(clk), .reset(reset), .ctl(ctl), .ir(ir),
    .memData(memData), .panelAddr(cmd.addr),
    .pc(pc), .ma(ma), .incWord(incWord)
  );

  pdp8AccUnit accUnit_i (
    .clk(clk), .reset(reset), .ctl(ctl), .ir(ir), .memData(memData),
    .ac(ac), .link(link), .skip(skip)
  );

  pdp8Memory memory_i (
    .clk(clk), .addr(memAddr), .wrData(wrData),
    .write(ctl.memWrite), .rdData(memData)
  );

endmodule

`default_nettype wire

/* src/pdp8Memory.sv */
// PDP-8 core memory
// 4096 x 12 words, one port, registered read and synchronous write

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module pdp8Memory (
  input  logic clk,
  input  logic [`PDP8_ADDR_BITS-1:0] addr,
  input  pdp8Pkg::word wrData,
  input  logic write,
  output pdp8Pkg::word rdData
);

  localparam int Depth = 1 << `PDP8_ADDR_BITS;

  pdp8Pkg::word mem [Depth];

  // Power-up contents
  initial begin
    for (int i = 0; i < Depth; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= wrData;
    end
    // Old word on a write cycle
    rdData <= mem[addr];
  end

endmodule

`default_nettype wire

/* tests/tbPdp8.sv */
// PDP-8 core testbench
// Directed tests through the front-panel port covering deposit and
// examine, memory reference programs, ISZ and JMS loops, auto-index
// and the operate groups

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module tbPdp8;

  localparam int PanelLimit = 10;
  localparam int RunLimit = 2000;

  logic clk = 1'b0;
  logic reset;
  logic req;
  logic ack;
  pdp8Pkg::panelCmd cmd;
  pdp8Pkg::panelResp resp;
  pdp8Pkg::word prog[$];

  pdp8Core dut_i (
    .clk(clk), .reset(reset), .cmd(cmd), .req(req), .ack(ack), .resp(resp)
  );

  always #50 clk = ~clk;

  task automatic reportFailure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expectWord(input string what, input pdp8Pkg::word got,
                            input pdp8Pkg::word exp);
    assert (got === exp) else
      reportFailure($sformatf("error at %0t: %s is %o, expected %o", $time, what, got, exp));
  endtask

  // Sampled on the falling edge away from DUT updates
  task automatic waitForAck(input logic level, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ack !== level) begin
      if (cycles >= limit) begin
        reportFailure($sformatf("ack did not go to %0b within %0d cycles, time %0t",
                                level, limit, $time));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // One four-phase transfer on the panel port
  task automatic panelCommand(input pdp8Pkg::panelOp op, input pdp8Pkg::word addr,
                              input pdp8Pkg::word data, input int holdCycles,
                              input int limit, output pdp8Pkg::panelResp r);
    @(posedge clk);
    cmd <= '{op: op, addr: addr, data: data};
    req <= 1'b1;
    waitForAck(1'b1, limit);
    r = resp;
    for (int i = 0; i < holdCycles; i++) begin
      @(negedge clk);
      assert (ack === 1'b1) else
        reportFailure($sformatf("ack dropped while req was still high, time %0t", $time));
    end
    @(posedge clk);
    req <= 1'b0;
    waitForAck(1'b0, PanelLimit);
  endtask

  task automatic deposit(input pdp8Pkg::word addr, input pdp8Pkg::word data);
    pdp8Pkg::panelResp r;
    panelCommand(pdp8Pkg::opDeposit, addr, data, 0, PanelLimit, r);
  endtask

  task automatic examine(input pdp8Pkg::word addr, output pdp8Pkg::word data);
    pdp8Pkg::panelResp r;
    panelCommand(pdp8Pkg::opExamine, addr, '0, 0, PanelLimit, r);
    data = r.data;
  endtask

  task automatic run(input pdp8Pkg::word startAddr, output pdp8Pkg::panelResp r);
    panelCommand(pdp8Pkg::opRun, startAddr, '0, 0, RunLimit, r);
  endtask

  task automatic loadProgram(input pdp8Pkg::word base);
    for (int i = 0; i < prog.size(); i++) begin
      deposit(base + 12'(i), prog[i]);
    end
  endtask

  function automatic pdp8Pkg::word randomWord();
    logic [31:0] r;
    r = $urandom();
    return r[11:0];
  endfunction

  // Assembles a memory reference on page zero or the instruction's page
  function automatic pdp8Pkg::word memRef(input pdp8Pkg::memOp op, input logic indirect,
                                         input pdp8Pkg::word target);
    logic currentPage;
    currentPage = target[11:7] != 5'b0;
    return {op, indirect, currentPage, target[6:0]};
  endfunction

  function automatic logic [12:0] rotateLeft(input logic [12:0] lac);
    return {lac[11:0], lac[12]};
  endfunction

  function automatic logic [12:0] rotateRight(input logic [12:0] lac);
    return {lac[0], lac[12:1]};
  endfunction

  // Link in bit 12 and AC below
  function automatic logic [12:0] group1Model(input pdp8Pkg::word instr,
                                              input pdp8Pkg::word acIn, input logic linkIn);
    logic [12:0] lac;
    lac = {linkIn, acIn};
    case (instr)
      12'o7040: lac[11:0] = ~lac[11:0];
      12'o7020: lac[12] = ~lac[12];
      12'o7001: lac = lac + 13'd1;
      12'o7002: lac = {lac[12], lac[5:0], lac[11:6]};
      12'o7004: lac = rotateLeft(lac);
      12'o7006: lac = rotateLeft(rotateLeft(lac));
      12'o7010: lac = rotateRight(lac);
      12'o7012: lac = rotateRight(rotateRight(lac));
      default: lac = lac;
    endcase
    return lac;
  endfunction

  // Reversed sense skips only when none of the selected conditions holds
  function automatic logic skipModel(input pdp8Pkg::word instr, input pdp8Pkg::word acIn,
                                     input logic linkIn);
    logic anyHolds;
    anyHolds = ((instr & 12'o0100) != 0 && acIn[11]) ||
               ((instr & 12'o0040) != 0 && acIn == 12'o0000) ||
               ((instr & 12'o0020) != 0 && linkIn);
    return ((instr & 12'o0010) != 0) ? !anyHolds : anyHolds;
  endfunction

  task automatic panelReadback();
    pdp8Pkg::word addr;
    pdp8Pkg::word data;
    pdp8Pkg::panelResp r;
    assert (ack === 1'b0) else
      reportFailure($sformatf("error at %0t: ack is high after reset", $time));
    for (int i = 0; i < 20; i++) begin
      addr = randomWord();
      data = randomWord();
      panelCommand(pdp8Pkg::opDeposit, addr, data, 3, PanelLimit, r);
      panelCommand(pdp8Pkg::opExamine, addr, '0, 3, PanelLimit, r);
      expectWord($sformatf("examine of %o", addr), r.data, data);
    end
  endtask

  task automatic addAndStore();
    pdp8Pkg::word a;
    pdp8Pkg::word b;
    pdp8Pkg::word mask;
    pdp8Pkg::word got;
    logic [12:0] total;
    pdp8Pkg::panelResp r;
    prog.delete();
    prog.push_back(12'o7300);
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b0, 12'o0300));
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b0, 12'o0301));
    prog.push_back(memRef(pdp8Pkg::opDca, 1'b0, 12'o0303));
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b0, 12'o0300));
    prog.push_back(memRef(pdp8Pkg::opAnd, 1'b0, 12'o0302));
    prog.push_back(memRef(pdp8Pkg::opDca, 1'b0, 12'o0304));
    prog.push_back(12'o7402);
    loadProgram(12'o0200);
    for (int i = 0; i < 4; i++) begin
      a = randomWord();
      b = randomWord();
      mask = randomWord();
      // First pass always carries out
      if (i == 0) begin
        a = a | 12'o4000;
        b = b | 12'o4000;
      end
      total = {1'b0, a} + {1'b0, b};
      deposit(12'o0300, a);
      deposit(12'o0301, b);
      deposit(12'o0302, mask);
      run(12'o0200, r);
      expectWord("ac after DCA", r.ac, 12'o0000);
      expectWord("link after TAD", {11'b0, r.link}, {11'b0, total[12]});
      expectWord("pc at halt", r.pc, 12'o0210);
      examine(12'o0303, got);
      expectWord("stored sum", got, total[11:0]);
      examine(12'o0304, got);
      expectWord("stored mask", got, a & mask);
    end
  endtask

  task automatic iszSubroutineLoop();
    pdp8Pkg::word startCount;
    pdp8Pkg::word passes;
    pdp8Pkg::word got;
    pdp8Pkg::panelResp r;
    startCount = 12'o7773;
    passes = 12'o0000 - startCount;
    prog.delete();
    prog.push_back(12'o7300);
    prog.push_back(memRef(pdp8Pkg::opJms, 1'b0, 12'o0420));
    prog.push_back(memRef(pdp8Pkg::opIsz, 1'b0, 12'o0451));
    prog.push_back(memRef(pdp8Pkg::opJmp, 1'b0, 12'o0401));
    prog.push_back(12'o7402);
    loadProgram(12'o0400);
    // Subroutine counts its calls in AC
    prog.delete();
    prog.push_back(12'o0000);
    prog.push_back(12'o7001);
    prog.push_back(memRef(pdp8Pkg::opJmp, 1'b1, 12'o0420));
    loadProgram(12'o0420);
    deposit(12'o0451, startCount);
    run(12'o0400, r);
    expectWord("subroutine calls in ac", r.ac, passes);
    expectWord("pc after ISZ loop", r.pc, 12'o0405);
    examine(12'o0451, got);
    expectWord("loop counter", got, 12'o0000);
    examine(12'o0420, got);
    expectWord("JMS return address", got, 12'o0402);
  endtask

  task automatic autoIndexTable();
    pdp8Pkg::word entries [4];
    pdp8Pkg::word got;
    pdp8Pkg::panelResp r;
    prog.delete();
    prog.push_back(12'o7300);
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b1, `PDP8_AUTOINDEX_FIRST));
    prog.push_back(12'o7402);
    loadProgram(12'o0600);
    for (int i = 0; i < 4; i++) begin
      entries[i] = randomWord();
      deposit(12'o1000 + 12'(i), entries[i]);
    end
    // Pointer sits one below the table
    deposit(`PDP8_AUTOINDEX_FIRST, 12'o0777);
    for (int i = 0; i < 4; i++) begin
      run(12'o0600, r);
      expectWord($sformatf("ac from table entry %0d", i), r.ac, entries[i]);
      expectWord("pc after auto-index program", r.pc, 12'o0603);
      examine(`PDP8_AUTOINDEX_FIRST, got);
      expectWord("auto-index pointer", got, 12'o1000 + 12'(i));
    end
  endtask

  task automatic operateGroups();
    pdp8Pkg::word g1Ops [8];
    pdp8Pkg::word g2Ops [6];
    pdp8Pkg::word value;
    pdp8Pkg::word taken;
    pdp8Pkg::word notTaken;
    logic linkIn;
    logic expSkip;
    logic [12:0] expLac;
    pdp8Pkg::panelResp r;
    g1Ops = '{12'o7040, 12'o7001, 12'o7004, 12'o7010, 12'o7006, 12'o7012, 12'o7002, 12'o7020};
    g2Ops = '{12'o7500, 12'o7440, 12'o7420, 12'o7510, 12'o7450, 12'o7430};
    // Words 1202 and 1203 are patched per case
    prog.delete();
    prog.push_back(12'o7300);
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b0, 12'o1300));
    prog.push_back(12'o7000);
    prog.push_back(12'o7000);
    prog.push_back(12'o7402);
    loadProgram(12'o1200);
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        value = randomWord();
        linkIn = (k % 2) == 1;
        deposit(12'o1202, linkIn ? 12'o7020 : 12'o7000);
        deposit(12'o1203, g1Ops[i]);
        deposit(12'o1300, value);
        run(12'o1200, r);
        expLac = group1Model(g1Ops[i], value, linkIn);
        expectWord($sformatf("ac after %o on %o", g1Ops[i], value), r.ac, expLac[11:0]);
        expectWord($sformatf("link after %o on %o", g1Ops[i], value),
                   {11'b0, r.link}, {11'b0, expLac[12]});
        expectWord("pc after group 1 program", r.pc, 12'o1205);
      end
    end
    // Skip lands on 1405 and no skip takes the JMP to 1410
    prog.delete();
    prog.push_back(12'o7300);
    prog.push_back(memRef(pdp8Pkg::opTad, 1'b0, 12'o1500));
    prog.push_back(12'o7000);
    prog.push_back(12'o7000);
    prog.push_back(memRef(pdp8Pkg::opJmp, 1'b0, 12'o1410));
    prog.push_back(12'o7201);
    prog.push_back(memRef(pdp8Pkg::opDca, 1'b0, 12'o1502));
    prog.push_back(12'o7402);
    prog.push_back(12'o7201);
    prog.push_back(memRef(pdp8Pkg::opDca, 1'b0, 12'o1501));
    prog.push_back(12'o7402);
    loadProgram(12'o1400);
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 6; k++) begin
        value = randomWord();
        if (k / 2 == 0) value = 12'o0000;
        else if (k / 2 == 1) value = value & 12'o3777;
        else value = value | 12'o4000;
        linkIn = (k % 2) == 1;
        deposit(12'o1402, linkIn ? 12'o7020 : 12'o7000);
        deposit(12'o1403, g2Ops[i]);
        deposit(12'o1500, value);
        deposit(12'o1501, 12'o0000);
        deposit(12'o1502, 12'o0000);
        run(12'o1400, r);
        expSkip = skipModel(g2Ops[i], value, linkIn);
        examine(12'o1502, taken);
        examine(12'o1501, notTaken);
        expectWord($sformatf("skip cell after %o, ac %o link %0b", g2Ops[i], value, linkIn),
                   taken, expSkip ? 12'o0001 : 12'o0000);
        expectWord($sformatf("no-skip cell after %o, ac %o link %0b", g2Ops[i], value, linkIn),
                   notTaken, expSkip ? 12'o0000 : 12'o0001);
        expectWord("pc after group 2 program", r.pc, expSkip ? 12'o1410 : 12'o1413);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h5ecc8271));
    reset = 1'b1;
    req = 1'b0;
    cmd = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    panelReadback();
    addAndStore();
    iszSubroutineLoop();
    autoIndexTable();
    operateGroups();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
